//--- filelist.f
verilog/drawPkg.sv
verilog/spriteSequencer.sv
verilog/vertexPlacer.sv
verilog/displayListBuilder.sv
sim/tbClock.sv
sim/displayListBuilderTb.sv

//--- Bender.yml
package:
  name: display_list_builder

sources:
  - verilog/drawPkg.sv
  - verilog/spriteSequencer.sv
  - verilog/vertexPlacer.sv
  - verilog/displayListBuilder.sv
  - target: simulation
    files:
      - sim/tbClock.sv
      - sim/displayListBuilderTb.sv

//--- sim/displayListBuilderTb.sv
// display list builder testbench with random sprite rom, ram model and reference list check

module displayListBuilderTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int coordW   = 8;
    localparam int adrW     = 16;
    localparam int vertW    = 2*coordW + 2;
    localparam int numTests = 6;

    logic               clk;
    logic               rst;
    logic               halt;
    logic               go;
    logic [vertW-1:0]   dataRom;
    logic [adrW-1:0]    adrRom;
    logic [vertW-1:0]   dataWrite;
    logic [adrW-1:0]    adrWrite;
    logic [coordW-1:0]  xCursor;
    logic [coordW-1:0]  yCursor;
    logic [coordW-1:0]  enemyX [3];
    logic [coordW-1:0]  enemyY [3];
    logic [adrW-1:0]    enemyAdr [3];
    logic [2:0]         spawnEnemy;
    logic [coordW-1:0]  missileX;
    logic [coordW-1:0]  missileY;
    logic               spawnMissile;
    logic [2:0]         baseNuked;

    logic [vertW-1:0]   rom [0:65535];
    logic [vertW-1:0]   ram [0:65535];
    logic [vertW-1:0]   expList [$];   // reference display list

    // image starts in order frame, map, cursor, base1-3, nuke, launch base, missile, enemies
    logic [adrW-1:0] imgStart [12] = '{drawPkg::adrFrameStart, drawPkg::adrMapStart,
        drawPkg::adrCursorStart, drawPkg::adrBase1Start, drawPkg::adrBase2Start,
        drawPkg::adrBase3Start, drawPkg::adrNukeStart, drawPkg::adrLaunchBaseStart,
        drawPkg::adrMissileStart, 16'h0700, 16'h0740, 16'h0780};
    logic [adrW-1:0]   baseStart [3] = '{drawPkg::adrBase1Start, drawPkg::adrBase2Start,
        drawPkg::adrBase3Start};
    logic [coordW-1:0] baseX [3] = '{drawPkg::base1X, drawPkg::base2X, drawPkg::base3X};
    logic [coordW-1:0] baseY [3] = '{drawPkg::base1Y, drawPkg::base2Y, drawPkg::base3Y};
    string testNames [numTests] = '{"baseline", "enemies", "nukes", "missile",
        "random1", "random2"};

    int          romWords = 0;  // image words including end markers
    int          cycles = 0;
    int          cycleLimit;
    int          testErrs;
    int          totalErrs = 0;

    tbClock #(.periodNs(100), .resetCycles(5)) u_clk (.clk, .rst);

    displayListBuilder #(.coordWidth(coordW), .adrWidth(adrW)) u_dut (
        .clk, .rst, .halt, .go, .dataRom, .adrRom, .dataWrite, .adrWrite,
        .xCursor, .yCursor,
        .xEnemy1(enemyX[0]), .yEnemy1(enemyY[0]),
        .xEnemy2(enemyX[1]), .yEnemy2(enemyY[1]),
        .xEnemy3(enemyX[2]), .yEnemy3(enemyY[2]),
        .xMissile(missileX), .yMissile(missileY),
        .adrEnemy1(enemyAdr[0]), .adrEnemy2(enemyAdr[1]), .adrEnemy3(enemyAdr[2]),
        .spawnEnemy1(spawnEnemy[0]), .spawnEnemy2(spawnEnemy[1]),
        .spawnEnemy3(spawnEnemy[2]), .spawnMissile, .baseNuked
    );

    assign dataRom = rom[adrRom];   // combinational rom read
    always @(posedge clk) ram[adrWrite] <= dataWrite;   // no write enable

    // run limit from total image length
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("timeout: list not finished after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus and reference model
    //////////////////////////////////////////////////////////////////////
    task automatic buildRom();
        int n;
        for (int a = 0; a < 65536; a++) rom[a] = {a[15:0], 2'b00}; // unused words
        for (int img = 0; img < 12; img++) begin
            n = 1 + $urandom % 6;
            for (int k = 0; k < n; k++)
                rom[imgStart[img] + k] = {8'($urandom), 8'($urandom), 2'($urandom % 3)};
            rom[imgStart[img] + n] = {8'($urandom), 8'($urandom), 2'b11}; // end marker
            romWords += n + 1;
        end
    endtask

    task automatic pickInputs(input int t);
        xCursor  = $urandom;
        yCursor  = $urandom;
        missileX = $urandom;
        missileY = $urandom;
        for (int e = 0; e < 3; e++) begin
            enemyX[e]   = $urandom;
            enemyY[e]   = $urandom;
            enemyAdr[e] = imgStart[9 + $urandom % 3]; // any of the three enemy images
        end
        spawnEnemy   = (t == 0) ? 3'b000 : (t == 1) ? 3'($urandom % 7 + 1) : 3'($urandom);
        baseNuked    = (t < 2) ? 3'b000 : (t == 2) ? 3'($urandom % 7 + 1) : 3'($urandom);
        spawnMissile = (t < 3) ? 1'b0 : (t == 3) ? 1'b1 : 1'($urandom);
    endtask

    // one sprite moved by its position minus midpoint with 8 bit wrap
    task automatic addImage(input logic [adrW-1:0] start, input logic [7:0] midX, midY,
                            input logic [7:0] posX, posY);
        logic [vertW-1:0] w;
        for (int k = 0; k < 16; k++) begin
            w = rom[16'(start + k)];
            if (w[drawPkg::lineBit] && w[drawPkg::posBit]) break;
            expList.push_back({8'(w[drawPkg::xMsb -: 8] - midX + posX),
                               8'(w[drawPkg::yMsb -: 8] - midY + posY), w[1:0]});
        end
    endtask

    task automatic buildExpected();
        expList.delete();
        expList.push_back(18'b01); // origin entry
        addImage(drawPkg::adrFrameStart, 0, 0, 0, 0);
        addImage(drawPkg::adrMapStart, 0, 0, 0, 0);
        addImage(drawPkg::adrCursorStart, drawPkg::cursorMidX, drawPkg::cursorMidY,
                 xCursor, yCursor);
        for (int e = 0; e < 3; e++)
            if (spawnEnemy[e])
                addImage(enemyAdr[e], drawPkg::enemyMidX, drawPkg::enemyMidY,
                         enemyX[e], enemyY[e]);
        for (int b = 0; b < 3; b++) begin
            if (baseNuked[b])
                addImage(drawPkg::adrNukeStart, drawPkg::nukeMidX, drawPkg::nukeMidY,
                         baseX[b], baseY[b]);
            else
                addImage(baseStart[b], drawPkg::baseMidX, drawPkg::baseMidY,
                         baseX[b], baseY[b]);
        end
        addImage(drawPkg::adrLaunchBaseStart, drawPkg::launchBaseMidX,
                 drawPkg::launchBaseMidY, drawPkg::launchBaseX, drawPkg::launchBaseY);
        if (spawnMissile)
            addImage(drawPkg::adrMissileStart, drawPkg::missileMidX, drawPkg::missileMidY,
                     missileX, missileY);
        expList.push_back(18'b11); // end entry
    endtask

    task automatic checkList(input int t);
        buildExpected();
        for (int i = 0; i < expList.size(); i++) begin
            assert (ram[i] === expList[i]) else begin
                $display("mismatch %s entry %0d expected %h actual %h",
                         testNames[t], i, expList[i], ram[i]);
                testErrs++;
            end
        end
        assert (adrWrite == adrW'(expList.size() - 1)) else begin
            $display("mismatch %s end address expected %0d actual %0d",
                     testNames[t], expList.size() - 1, adrWrite);
            testErrs++;
        end
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #1; // drive and sample just past the edge
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(87));
        buildRom();
        cycleLimit = 2 * (numTests * (romWords + 32));
        halt = 1'b1;  // display side busy so the first list is held
        pickInputs(0);
        while (rst !== 1'b0) @(posedge clk);
        #1;
        testErrs = 0;
        assert (go === 1'b0) else begin
            $display("go was high right after reset");
            testErrs++;
        end
        for (int t = 0; t < numTests; t++) begin
            if (t > 0) begin
                testErrs = 0;
                halt = 1'b0;         // display side done with old list
                pickInputs(t);       // fresh game state for the rebuild
                repeat (3) begin
                    stepCycle();
                    assert (adrRom === '0) else begin
                        $display("mismatch %s idle rom address expected 0 actual %h",
                                 testNames[t], adrRom);
                        testErrs++;
                    end
                end
                halt = 1'b1;
                stepCycle();
                assert (go === 1'b0) else begin
                    $display("go stayed high after halt returned in %s", testNames[t]);
                    testErrs++;
                end
            end
            do stepCycle(); while (go !== 1'b1);
            checkList(t);
            repeat (4) begin
                stepCycle();
                assert (go === 1'b1) else begin
                    $display("go dropped while halt was held in %s", testNames[t]);
                    testErrs++;
                end
            end
            $display("test %0d %s: %0d entries, %0d errors", t, testNames[t],
                     expList.size(), testErrs);
            totalErrs += testErrs;
        end
        $display("summary: %0d tests run, %0d checks wrong", numTests, totalErrs);
        if (totalErrs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- sim/tbClock.sv
// tbClock: free-running testbench clock and power-on reset for the display list testbench

module tbClock #(
    parameter int periodNs    = 100,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk; // 50 ns high, 50 ns low
    end

    // reset held for a fixed number of edges, released just after an edge
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

//--- verilog/displayListBuilder.sv
// displayListBuilder: builds the per-frame vector display list from rom sprites into ram

module displayListBuilder #(
    parameter int coordWidth = 8,
    parameter int adrWidth   = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     halt,
    output logic                     go,
    input  logic [2*coordWidth+1:0]  dataRom,
    output logic [adrWidth-1:0]      adrRom,
    output logic [2*coordWidth+1:0]  dataWrite,
    output logic [adrWidth-1:0]      adrWrite,
    input  logic [coordWidth-1:0]    xCursor,
    input  logic [coordWidth-1:0]    yCursor,
    input  logic [coordWidth-1:0]    xEnemy1,
    input  logic [coordWidth-1:0]    yEnemy1,
    input  logic [coordWidth-1:0]    xEnemy2,
    input  logic [coordWidth-1:0]    yEnemy2,
    input  logic [coordWidth-1:0]    xEnemy3,
    input  logic [coordWidth-1:0]    yEnemy3,
    input  logic [coordWidth-1:0]    xMissile,
    input  logic [coordWidth-1:0]    yMissile,
    input  logic [adrWidth-1:0]      adrEnemy1,
    input  logic [adrWidth-1:0]      adrEnemy2,
    input  logic [adrWidth-1:0]      adrEnemy3,
    input  logic                     spawnEnemy1,
    input  logic                     spawnEnemy2,
    input  logic                     spawnEnemy3,
    input  logic                     spawnMissile,
    input  logic [2:0]               baseNuked    // bit n set draws the nuke over base n+1
);

    drawPkg::objKind_t objKind;
    logic              vertexValid;
    logic              frameStart;
    logic              frameEnd;

    // walks the rom and decides what gets written
    spriteSequencer #(.coordWidth(coordWidth), .adrWidth(adrWidth)) u_seq (
        .clk, .rst, .halt, .dataRom,
        .adrEnemy1, .adrEnemy2, .adrEnemy3,
        .spawnEnemy1, .spawnEnemy2, .spawnEnemy3, .spawnMissile, .baseNuked,
        .adrRom, .objKind, .vertexValid, .frameStart, .frameEnd, .go
    );

    // places each vertex on screen, one cycle behind the rom read
    vertexPlacer #(.coordWidth(coordWidth), .adrWidth(adrWidth)) u_place (
        .clk, .rst, .objKind, .dataRom, .vertexValid, .frameStart, .frameEnd,
        .xCursor, .yCursor, .xEnemy1, .yEnemy1, .xEnemy2, .yEnemy2,
        .xEnemy3, .yEnemy3, .xMissile, .yMissile,
        .adrWrite, .dataWrite
    );

endmodule

//--- verilog/vertexPlacer.sv
// vertexPlacer: translates sprite vertices to screen space and owns the display list ram writes

module vertexPlacer #(
    parameter int coordWidth = 8,
    parameter int adrWidth   = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  drawPkg::objKind_t        objKind,
    input  logic [2*coordWidth+1:0]  dataRom,
    input  logic                     vertexValid,
    input  logic                     frameStart,
    input  logic                     frameEnd,
    input  logic [coordWidth-1:0]    xCursor,
    input  logic [coordWidth-1:0]    yCursor,
    input  logic [coordWidth-1:0]    xEnemy1,
    input  logic [coordWidth-1:0]    yEnemy1,
    input  logic [coordWidth-1:0]    xEnemy2,
    input  logic [coordWidth-1:0]    yEnemy2,
    input  logic [coordWidth-1:0]    xEnemy3,
    input  logic [coordWidth-1:0]    yEnemy3,
    input  logic [coordWidth-1:0]    xMissile,
    input  logic [coordWidth-1:0]    yMissile,
    output logic [adrWidth-1:0]      adrWrite,
    output logic [2*coordWidth+1:0]  dataWrite
);

    localparam int vertexWidth = 2*coordWidth + 2;

    logic [coordWidth-1:0]  xRom;
    logic [coordWidth-1:0]  yRom;
    logic [coordWidth-1:0]  posX;
    logic [coordWidth-1:0]  posY;
    logic [coordWidth-1:0]  midX;
    logic [coordWidth-1:0]  midY;
    logic [coordWidth-1:0]  xScreen;
    logic [coordWidth-1:0]  yScreen;
    logic [vertexWidth-1:0] placed;

    assign xRom = dataRom[drawPkg::xMsb -: coordWidth];
    assign yRom = dataRom[drawPkg::yMsb -: coordWidth];

    //////////////////////////////////////////////////////////////////////
    // object position and sprite midpoint
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        {posX, posY} = '0; // frame and map are already in screen space
        {midX, midY} = '0;
        case (objKind)
            drawPkg::cursor:  {posX, posY} = {xCursor, yCursor};
            drawPkg::enemy1:  {posX, posY} = {xEnemy1, yEnemy1};
            drawPkg::enemy2:  {posX, posY} = {xEnemy2, yEnemy2};
            drawPkg::enemy3:  {posX, posY} = {xEnemy3, yEnemy3};
            drawPkg::missile: {posX, posY} = {xMissile, yMissile};
            drawPkg::base1, drawPkg::nuke1:
                {posX, posY} = {coordWidth'(drawPkg::base1X), coordWidth'(drawPkg::base1Y)};
            drawPkg::base2, drawPkg::nuke2:
                {posX, posY} = {coordWidth'(drawPkg::base2X), coordWidth'(drawPkg::base2Y)};
            drawPkg::base3, drawPkg::nuke3:
                {posX, posY} = {coordWidth'(drawPkg::base3X), coordWidth'(drawPkg::base3Y)};
            drawPkg::launchBase:
                {posX, posY} = {coordWidth'(drawPkg::launchBaseX),
                                coordWidth'(drawPkg::launchBaseY)};
            default: ;
        endcase
        case (objKind)
            drawPkg::cursor:
                {midX, midY} = {coordWidth'(drawPkg::cursorMidX), coordWidth'(drawPkg::cursorMidY)};
            drawPkg::enemy1, drawPkg::enemy2, drawPkg::enemy3:
                {midX, midY} = {coordWidth'(drawPkg::enemyMidX), coordWidth'(drawPkg::enemyMidY)};
            drawPkg::base1, drawPkg::base2, drawPkg::base3:
                {midX, midY} = {coordWidth'(drawPkg::baseMidX), coordWidth'(drawPkg::baseMidY)};
            drawPkg::nuke1, drawPkg::nuke2, drawPkg::nuke3:
                {midX, midY} = {coordWidth'(drawPkg::nukeMidX), coordWidth'(drawPkg::nukeMidY)};
            drawPkg::launchBase:
                {midX, midY} = {coordWidth'(drawPkg::launchBaseMidX),
                                coordWidth'(drawPkg::launchBaseMidY)};
            drawPkg::missile:
                {midX, midY} = {coordWidth'(drawPkg::missileMidX),
                                coordWidth'(drawPkg::missileMidY)};
            default: ;
        endcase
    end

    // wraps at coordWidth, line and pos pass through
    assign xScreen = xRom - midX + posX;
    assign yScreen = yRom - midY + posY;
    assign placed  = {xScreen, yScreen, dataRom[drawPkg::lineBit], dataRom[drawPkg::posBit]};

    //////////////////////////////////////////////////////////////////////
    // ram write port
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            adrWrite <= '0;
        end else if (frameStart) begin
            adrWrite <= '0;
            dataWrite <= {{2*coordWidth{1'b0}}, 2'b01}; // origin, beam moves to 0,0
        end else if (frameEnd) begin
            adrWrite <= adrWrite + 1'b1;
            dataWrite <= {{2*coordWidth{1'b0}}, 2'b11}; // end of list
        end else if (vertexValid) begin
            adrWrite <= adrWrite + 1'b1;
            dataWrite <= placed;
        end
    end

    // list grows one entry at a time, restarting only at the origin
    adrStep : assert property (@(posedge clk) disable iff (rst)
        (adrWrite != $past(adrWrite)) |->
            (adrWrite == adrWidth'($past(adrWrite) + 1'b1)) || ($past(frameStart) && adrWrite == '0));

endmodule

//--- verilog/spriteSequencer.sv
// object FSM that walks rom sprite images, skips unspawned objects and drives go

module spriteSequencer #(
    parameter int coordWidth = 8,
    parameter int adrWidth   = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     halt,
    input  logic [2*coordWidth+1:0]  dataRom,
    input  logic [adrWidth-1:0]      adrEnemy1,
    input  logic [adrWidth-1:0]      adrEnemy2,
    input  logic [adrWidth-1:0]      adrEnemy3,
    input  logic                     spawnEnemy1,
    input  logic                     spawnEnemy2,
    input  logic                     spawnEnemy3,
    input  logic                     spawnMissile,
    input  logic [2:0]               baseNuked,
    output logic [adrWidth-1:0]      adrRom,
    output drawPkg::objKind_t        objKind,
    output logic                     vertexValid,
    output logic                     frameStart,
    output logic                     frameEnd,
    output logic                     go
);

    localparam int vertexWidth = 2*coordWidth + 2;

    // slots sFrame..sMissile must stay contiguous and in drawing order
    typedef enum logic [3:0] {
        sReset, sFrame, sMap, sCursor,
        sEnemy1, sEnemy2, sEnemy3,
        sBase1, sBase2, sBase3, sLaunchBase, sMissile,
        sEnd, sDone, sWait
    } stateT;

    stateT state;
    stateT stateNext;

    logic                    endMark;    // line and pos both set
    logic                    spawned;    // current slot is drawn at all
    logic                    slotActive;
    logic                    advance;    // last cycle of this slot
    logic [adrWidth-1:0]     nextStart;
    drawPkg::objKind_t       nextKind;
    logic [vertexWidth-1:0]  romWord;

    assign romWord = dataRom;
    assign endMark = romWord[drawPkg::lineBit] & romWord[drawPkg::posBit];

    //////////////////////////////////////////////////////////////////////
    // slot decode and strobes to the placer
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (state)
            sEnemy1:  spawned = spawnEnemy1;
            sEnemy2:  spawned = spawnEnemy2;
            sEnemy3:  spawned = spawnEnemy3;
            sMissile: spawned = spawnMissile;
            default:  spawned = 1'b1; // fixed images are always drawn
        endcase
        slotActive  = state inside {[sFrame:sMissile]};
        advance     = slotActive && (endMark || !spawned); // skip takes one cycle
        vertexValid = slotActive && spawned && !endMark;
        frameStart  = (state == sReset);
        frameEnd    = (state == sEnd);
    end

    // next state
    always_comb begin
        stateNext = state;
        if (state == sReset) begin
            stateNext = sFrame;
        end else if (advance || state == sEnd) begin
            stateNext = stateT'(state + 1'b1); // missile falls through to sEnd
        end else if (state == sDone) begin
            stateNext = halt ? sDone : sWait;
        end else if (state == sWait) begin
            stateNext = halt ? sReset : sWait;
        end
    end

    // start address and kind of the slot being entered
    always_comb begin
        nextStart = '0; // end, done and wait park the rom at 0
        nextKind  = objKind;
        case (stateNext)
            sFrame: begin
                nextStart = adrWidth'(drawPkg::adrFrameStart);
                nextKind  = drawPkg::frame;
            end
            sMap: begin
                nextStart = adrWidth'(drawPkg::adrMapStart);
                nextKind  = drawPkg::map;
            end
            sCursor: begin
                nextStart = adrWidth'(drawPkg::adrCursorStart);
                nextKind  = drawPkg::cursor;
            end
            sEnemy1: begin
                nextStart = adrEnemy1; // enemy images come from the game logic
                nextKind  = drawPkg::enemy1;
            end
            sEnemy2: begin
                nextStart = adrEnemy2;
                nextKind  = drawPkg::enemy2;
            end
            sEnemy3: begin
                nextStart = adrEnemy3;
                nextKind  = drawPkg::enemy3;
            end
            sBase1: begin
                nextStart = adrWidth'(baseNuked[0] ? drawPkg::adrNukeStart
                                                   : drawPkg::adrBase1Start);
                nextKind  = baseNuked[0] ? drawPkg::nuke1 : drawPkg::base1;
            end
            sBase2: begin
                nextStart = adrWidth'(baseNuked[1] ? drawPkg::adrNukeStart
                                                   : drawPkg::adrBase2Start);
                nextKind  = baseNuked[1] ? drawPkg::nuke2 : drawPkg::base2;
            end
            sBase3: begin
                nextStart = adrWidth'(baseNuked[2] ? drawPkg::adrNukeStart
                                                   : drawPkg::adrBase3Start);
                nextKind  = baseNuked[2] ? drawPkg::nuke3 : drawPkg::base3;
            end
            sLaunchBase: begin
                nextStart = adrWidth'(drawPkg::adrLaunchBaseStart);
                nextKind  = drawPkg::launchBase;
            end
            sMissile: begin
                nextStart = adrWidth'(drawPkg::adrMissileStart);
                nextKind  = drawPkg::missile;
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= sReset;
            adrRom  <= '0;
            objKind <= drawPkg::frame;
            go      <= 1'b0;
        end else begin
            state <= stateNext;
            go    <= (state == sDone) || (state == sWait && !halt); // drops as rebuild starts
            if (stateNext != state) begin
                adrRom  <= nextStart;
                objKind <= nextKind;
            end else if (slotActive) begin
                adrRom <= adrRom + 1'b1; // next vertex of the same image
            end
        end
    end

    // display side must never see go during a build
    goIdleOnly : assert property (@(posedge clk) disable iff (rst) slotActive |-> !go);

    // after a written word the walk stays in the same image
    wordStep : assert property (@(posedge clk) disable iff (rst)
        vertexValid |=> (adrRom == adrWidth'($past(adrRom) + 1'b1)));

endmodule

//--- verilog/drawPkg.sv
// drawPkg: object kinds, sprite image addresses, midpoints and fixed positions for the display list

package drawPkg;

    //////////////////////////////////////////////////////////////////////
    // object kinds, in the order the list is drawn (nukes replace bases)
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        frame,
        map,
        cursor,
        enemy1,
        enemy2,
        enemy3,
        base1,
        base2,
        base3,
        nuke1,
        nuke2,
        nuke3,
        launchBase,
        missile
    } objKind_t;

    //////////////////////////////////////////////////////////////////////
    // rom image start addresses
    //////////////////////////////////////////////////////////////////////
    localparam logic [15:0] adrFrameStart      = 16'h0000; // screen border
    localparam logic [15:0] adrMapStart        = 16'h0100; // landscape backdrop
    localparam logic [15:0] adrCursorStart     = 16'h0200;
    localparam logic [15:0] adrBase1Start      = 16'h0300;
    localparam logic [15:0] adrBase2Start      = 16'h0340;
    localparam logic [15:0] adrBase3Start      = 16'h0380;
    localparam logic [15:0] adrNukeStart       = 16'h0400; // shared by all three bases
    localparam logic [15:0] adrLaunchBaseStart = 16'h0500;
    localparam logic [15:0] adrMissileStart    = 16'h0600;

    // sprite-local midpoints, subtracted before the object position is added
    localparam logic [7:0] cursorMidX     = 8'd8;
    localparam logic [7:0] cursorMidY     = 8'd8;
    localparam logic [7:0] enemyMidX      = 8'd6;
    localparam logic [7:0] enemyMidY      = 8'd10;
    localparam logic [7:0] baseMidX       = 8'd12;
    localparam logic [7:0] baseMidY       = 8'd4;
    localparam logic [7:0] nukeMidX       = 8'd14;
    localparam logic [7:0] nukeMidY       = 8'd9;
    localparam logic [7:0] launchBaseMidX = 8'd10;
    localparam logic [7:0] launchBaseMidY = 8'd5;
    localparam logic [7:0] missileMidX    = 8'd2;
    localparam logic [7:0] missileMidY    = 8'd7;

    // fixed screen positions, bases spread along the ground line
    localparam logic [7:0] base1X      = 8'd40;
    localparam logic [7:0] base1Y      = 8'd20;
    localparam logic [7:0] base2X      = 8'd88;
    localparam logic [7:0] base2Y      = 8'd20;
    localparam logic [7:0] base3X      = 8'd168;
    localparam logic [7:0] base3Y      = 8'd20;
    localparam logic [7:0] launchBaseX = 8'd128;
    localparam logic [7:0] launchBaseY = 8'd16;

    //////////////////////////////////////////////////////////////////////
    // vertex word layout: {x, y, line, pos}
    //////////////////////////////////////////////////////////////////////
    localparam int xMsb    = 17;
    localparam int yMsb    = 9;
    localparam int lineBit = 1; // draw a line to this point
    localparam int posBit  = 0; // move the beam, line+pos together ends a sprite

endpackage
